/* build.f */
verilog/cpu_pkg.sv
verilog/wb_pkg.sv
verilog/issue_unit.sv
verilog/exec_unit.sv
verilog/rob.sv
verilog/commit_unit.sv
verilog/ooo_core_top.sv
dv/tb_ooo_core.sv

/* dv/tb_ooo_core.sv */
`timescale 1ns/100ps

module tb_ooo_core;
  import cpu_pkg::*;
  import wb_pkg::*;

  localparam int hs_limit = 200;
  localparam int drain_limit = 500;
  localparam int rob_slots = 4;

  logic                clk_in;
  logic                rst_in;
  logic                instr_valid;
  op_t                 instr_op;
  logic [reg_ix_w-1:0] instr_rd;
  logic [xlen-1:0]     instr_a;
  logic [xlen-1:0]     instr_b;
  logic [imm_w-1:0]    instr_imm;
  logic                instr_ready;
  logic                retire_valid;
  logic [reg_ix_w-1:0] retire_rd;
  logic [xlen-1:0]     retire_value;
  logic [reg_ix_w-1:0] rf_rd_addr;
  logic [xlen-1:0]     rf_rd_data;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [wb_addr_w-1:0] wb_adr;
  logic [wb_data_w-1:0] wb_dat_o;
  logic                wb_ack;

  // stimulus table, one row per instruction
  op_t                 tbl_op[$];
  logic [reg_ix_w-1:0] tbl_rd[$];
  logic [xlen-1:0]     tbl_a[$];
  logic [xlen-1:0]     tbl_b[$];
  logic [imm_w-1:0]    tbl_imm[$];

  // expected retires and stores in program order
  logic [reg_ix_w-1:0] exp_rd_q[$];
  logic [xlen-1:0]     exp_val_q[$];
  logic [xlen-1:0]     exp_adr_q[$];
  logic [xlen-1:0]     exp_dat_q[$];
  logic [xlen-1:0]     ref_rf[reg_count];

  integer    seed = 32'hbde21112;
  int        errors = 0;
  int        retired = 0;
  int        stored = 0;
  int        n_regops = 0;
  int        n_stores = 0;
  logic      timed_out = 1'b0;
  logic      saw_stall = 1'b0;
  wb_state_t bus_state;

  ooo_core_top #(.rob_depth(rob_slots)) dut (
    .clk_in, .rst_in,
    .instr_valid, .instr_op, .instr_rd, .instr_a, .instr_b, .instr_imm, .instr_ready,
    .retire_valid, .retire_rd, .retire_value,
    .rf_rd_addr, .rf_rd_data,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_ack
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, want);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
    end
  endtask

  task automatic add_entry(input op_t op, input logic [2:0] rd, input logic [31:0] a,
                           input logic [31:0] b, input logic [15:0] imm);
    tbl_op.push_back(op);
    tbl_rd.push_back(rd);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_imm.push_back(imm);
  endtask

  // instruction rules, low 32 bits kept
  function automatic logic [31:0] op_result(input op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_mul:  return a * b;
      default: return b;
    endcase
  endfunction

  // rows ahead of the holding register are all stores, so the rob is full of them
  function automatic logic behind_store_run(input int idx);
    logic all_st;
    all_st = (idx > rob_slots);
    for (int k = 2; k <= rob_slots + 1; k++) begin
      if (idx - k >= 0 && tbl_op[idx - k] != op_store) begin
        all_st = 1'b0;
      end
    end
    return all_st;
  endfunction

  // reference model walks the table in program order
  task automatic build_expected;
    logic [31:0] v;
    for (int r = 0; r < reg_count; r++) begin
      ref_rf[r] = '0;
    end
    for (int i = 0; i < tbl_op.size(); i++) begin
      if (tbl_op[i] == op_store) begin
        exp_adr_q.push_back(tbl_a[i] + {{16{tbl_imm[i][15]}}, tbl_imm[i]});
        exp_dat_q.push_back(tbl_b[i]);
        n_stores++;
      end else begin
        v = op_result(tbl_op[i], tbl_a[i], tbl_b[i]);
        exp_rd_q.push_back(tbl_rd[i]);
        exp_val_q.push_back(v);
        ref_rf[tbl_rd[i]] = v;
        n_regops++;
      end
    end
  endtask

  // hold valid until the rising edge where ready is seen high
  task automatic send_instr(input int idx);
    int waited;
    instr_valid = 1'b1;
    instr_op = tbl_op[idx];
    instr_rd = tbl_rd[idx];
    instr_a = tbl_a[idx];
    instr_b = tbl_b[idx];
    instr_imm = tbl_imm[idx];
    waited = 0;
    @(negedge clk_in);
    while (!instr_ready && waited < hs_limit) begin
      // mul lane stalls elsewhere do not count here
      if (behind_store_run(idx)) begin
        saw_stall = 1'b1;
      end
      waited++;
      @(negedge clk_in);
    end
    if (!instr_ready) begin
      timed_out = 1'b1;
      $display("timeout: instruction %0d not accepted after %0d cycles", idx, hs_limit);
    end else begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic wait_drain;
    int waited;
    waited = 0;
    while ((exp_rd_q.size() != 0 || exp_adr_q.size() != 0 || wb_cyc) &&
           waited < drain_limit) begin
      @(negedge clk_in);
      waited++;
    end
    if (exp_rd_q.size() != 0 || exp_adr_q.size() != 0 || wb_cyc) begin
      timed_out = 1'b1;
      bus_state = wb_cyc ? wb_busy : wb_idle;
      $display("timeout: %0d retires and %0d stores still pending, store port %s",
               exp_rd_q.size(), exp_adr_q.size(), bus_state.name());
    end
  endtask

  // read every register through the async port
  task automatic scan_regs(input logic use_ref);
    for (int r = 0; r < reg_count; r++) begin
      @(posedge clk_in);
      #1 rf_rd_addr = r[reg_ix_w-1:0];
      @(negedge clk_in);
      check_value($sformatf("rf[%0d]", r), rf_rd_data, use_ref ? ref_rf[r] : 32'd0);
      if (!use_ref) begin
        expect_true(!wb_cyc && !wb_stb && !retire_valid, "activity with no instructions");
      end
    end
  endtask

  // retire port, one register write per pulse
  initial begin : retire_monitor
    logic [reg_ix_w-1:0] rd;
    logic [xlen-1:0]     v;
    forever begin
      @(negedge clk_in);
      if (retire_valid) begin
        expect_true(exp_rd_q.size() != 0, "retire seen with nothing left to retire");
        if (exp_rd_q.size() != 0) begin
          rd = exp_rd_q.pop_front();
          v = exp_val_q.pop_front();
          check_value("retire_rd", retire_rd, rd);
          check_value("retire_value", retire_value, v);
          retired++;
        end
      end
    end
  end

  // memory slave with 0 to 5 wait cycles
  initial begin : wb_slave
    logic [xlen-1:0] adr0;
    logic [xlen-1:0] dat0;
    int waits;
    wb_ack = 1'b0;
    forever begin
      @(negedge clk_in);
      if (wb_cyc && wb_stb) begin
        adr0 = wb_adr;
        dat0 = wb_dat_o;
        expect_true(wb_we, "wb_we low during a store");
        expect_true(exp_adr_q.size() != 0, "Wishbone write with no store left");
        if (exp_adr_q.size() != 0) begin
          check_value("wb_adr", adr0, exp_adr_q.pop_front());
          check_value("wb_dat_o", dat0, exp_dat_q.pop_front());
          stored++;
        end
        waits = $unsigned($random(seed)) % 6;
        for (int w = 0; w < waits; w++) begin
          @(negedge clk_in);
          expect_true(wb_cyc && wb_stb, "cyc or stb dropped before ack");
          check_value("wb_adr", wb_adr, adr0);
          check_value("wb_dat_o", wb_dat_o, dat0);
        end
        @(posedge clk_in);
        #1 wb_ack = 1'b1;
        @(negedge clk_in);
        expect_true(wb_cyc && wb_stb, "cyc or stb low in the ack cycle");
        check_value("wb_adr", wb_adr, adr0);
        check_value("wb_dat_o", wb_dat_o, dat0);
        @(posedge clk_in);
        #1 wb_ack = 1'b0;
        // cycle ends on the edge after ack
        @(negedge clk_in);
        expect_true(!wb_cyc && !wb_stb, "cyc or stb still high after ack");
      end
    end
  end

  initial begin
    rst_in = 1'b1;
    instr_valid = 1'b0;
    instr_op = op_add;
    instr_rd = '0;
    instr_a = '0;
    instr_b = '0;
    instr_imm = '0;
    rf_rd_addr = '0;

    // alu, then mul overtaken by adds
    add_entry(op_add, 3'd1, 32'd5, 32'd7, 16'h0);
    add_entry(op_sub, 3'd2, 32'd3, 32'd10, 16'h0);
    add_entry(op_mul, 3'd3, 32'd6, 32'd7, 16'h0);
    add_entry(op_add, 3'd4, 32'd1, 32'd1, 16'h0);
    add_entry(op_add, 3'd5, 32'd100, 32'd23, 16'h0);
    add_entry(op_mul, 3'd6, 32'hffff_fffd, 32'd9, 16'h0);
    add_entry(op_sub, 3'd7, 32'd0, 32'd1, 16'h0);
    // back to back multiplies, negative operands
    add_entry(op_mul, 3'd1, 32'h1234_5678, 32'h9abc_def0, 16'h0);
    add_entry(op_mul, 3'd2, 32'hffff_fff9, 32'hffff_fffa, 16'h0);
    add_entry(op_add, 3'd3, 32'hffff_ffff, 32'd1, 16'h0);
    // four stores in a row fill the rob
    add_entry(op_store, 3'd0, 32'h0000_1000, 32'hdead_beef, 16'h0010);
    add_entry(op_store, 3'd0, 32'h0000_2000, 32'hcafe_f00d, 16'hfff0);
    add_entry(op_store, 3'd0, 32'h8000_0000, 32'h0000_0001, 16'h7fff);
    add_entry(op_store, 3'd0, 32'h0000_0040, 32'hffff_0000, 16'h8000);
    add_entry(op_add, 3'd4, 32'd11, 32'd22, 16'h0);
    add_entry(op_mul, 3'd5, 32'h0001_0000, 32'h0001_0000, 16'h0);
    add_entry(op_store, 3'd0, 32'h0000_0100, 32'h0000_55aa, 16'h0004);
    add_entry(op_sub, 3'd6, 32'h8000_0000, 32'd1, 16'h0);
    // same rd written by mul then add
    add_entry(op_mul, 3'd0, 32'd3, 32'd3, 16'h0);
    add_entry(op_add, 3'd0, 32'd1, 32'd2, 16'h0);
    add_entry(op_store, 3'd0, 32'h0000_0200, 32'h0000_1234, 16'h0000);
    add_entry(op_mul, 3'd7, 32'hffff_ffff, 32'hffff_ffff, 16'h0);
    add_entry(op_add, 3'd1, 32'h7fff_ffff, 32'd1, 16'h0);
    add_entry(op_sub, 3'd2, 32'd10, 32'd3, 16'h0);
    build_expected();

    repeat (4) @(posedge clk_in);
    #1 rst_in = 1'b0;

    // idle core, registers read zero
    scan_regs(1'b0);

    @(posedge clk_in);
    #1;
    for (int i = 0; i < tbl_op.size() && !timed_out; i++) begin
      send_instr(i);
    end
    instr_valid = 1'b0;

    if (!timed_out) begin
      wait_drain();
    end
    if (!timed_out) begin
      check_value("retired count", retired, n_regops);
      check_value("stored count", stored, n_stores);
      expect_true(saw_stall, "instr_ready never went low under store back-pressure");
      scan_regs(1'b1);
    end

    $display("errors=%0d retired=%0d/%0d stored=%0d/%0d timeout=%0d",
             errors, retired, n_regops, stored, n_stores, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/ooo_core_top.sv */
`timescale 1ns/100ps

module ooo_core_top #(
  parameter int rob_depth = 8
) (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         instr_valid,
  input  cpu_pkg::op_t                 instr_op,
  input  logic [cpu_pkg::reg_ix_w-1:0] instr_rd,
  input  logic [cpu_pkg::xlen-1:0]     instr_a,
  input  logic [cpu_pkg::xlen-1:0]     instr_b,
  input  logic [cpu_pkg::imm_w-1:0]    instr_imm,
  output logic                         instr_ready,
  output logic                         retire_valid,
  output logic [cpu_pkg::reg_ix_w-1:0] retire_rd,
  output logic [cpu_pkg::xlen-1:0]     retire_value,
  input  logic [cpu_pkg::reg_ix_w-1:0] rf_rd_addr,
  output logic [cpu_pkg::xlen-1:0]     rf_rd_data,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [wb_pkg::wb_addr_w-1:0] wb_adr,
  output logic [wb_pkg::wb_data_w-1:0] wb_dat_o,
  input  logic                         wb_ack
);
  import cpu_pkg::*;

  localparam int tag_w = $clog2(rob_depth);

  // dispatch bundle
  logic                disp_valid;
  op_t                 disp_op;
  logic [reg_ix_w-1:0] disp_rd;
  logic [xlen-1:0]     disp_a;
  logic [xlen-1:0]     disp_b;
  logic [imm_w-1:0]    disp_imm;
  logic                alloc_ready;
  logic [tag_w-1:0]    alloc_tag;
  logic                exec_ready;
  logic                disp_fire;

  // result bus
  logic                cdb_valid;
  logic [tag_w-1:0]    cdb_tag;
  logic [xlen-1:0]     cdb_value;
  logic [xlen-1:0]     cdb_addr_base;

  // rob head toward commit
  logic [reg_ix_w-1:0] head_rd;
  logic [xlen-1:0]     head_value;
  logic [xlen-1:0]     head_addr;
  logic                commit_valid;
  logic                store_valid;
  logic                store_done;

  // one fire condition for both rob and exec
  assign disp_fire = disp_valid && alloc_ready && exec_ready;

  issue_unit u_issue (
    .clk_in, .rst_in,
    .instr_valid, .instr_op, .instr_rd, .instr_a, .instr_b, .instr_imm,
    .instr_ready, .alloc_ready, .exec_ready,
    .disp_valid, .disp_op, .disp_rd, .disp_a, .disp_b, .disp_imm
  );

  exec_unit #(.rob_depth(rob_depth)) u_exec (
    .clk_in, .rst_in,
    .disp_fire, .disp_op, .disp_a, .disp_b, .disp_tag(alloc_tag),
    .exec_ready, .cdb_valid, .cdb_tag, .cdb_value, .cdb_addr_base
  );

  // head_op not needed by commit, the rob splits commit and store itself
  rob #(.rob_depth(rob_depth)) u_rob (
    .clk_in, .rst_in,
    .alloc_valid(disp_fire), .alloc_op(disp_op), .alloc_rd(disp_rd),
    .alloc_imm(disp_imm), .alloc_ready, .alloc_tag,
    .cdb_valid, .cdb_tag, .cdb_value, .cdb_addr_base,
    .head_op(), .head_rd, .head_value, .head_addr,
    .commit_valid, .store_valid, .store_done
  );

  commit_unit u_commit (
    .clk_in, .rst_in,
    .commit_valid, .store_valid, .head_rd, .head_value, .head_addr,
    .store_done, .retire_valid, .retire_rd, .retire_value,
    .rf_rd_addr, .rf_rd_data,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_ack
  );

endmodule

/* verilog/commit_unit.sv */
`timescale 1ns/100ps

module commit_unit (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         commit_valid,
  input  logic                         store_valid,
  input  logic [cpu_pkg::reg_ix_w-1:0] head_rd,
  input  logic [cpu_pkg::xlen-1:0]     head_value,
  input  logic [cpu_pkg::xlen-1:0]     head_addr,
  output logic                         store_done,
  output logic                         retire_valid,
  output logic [cpu_pkg::reg_ix_w-1:0] retire_rd,
  output logic [cpu_pkg::xlen-1:0]     retire_value,
  input  logic [cpu_pkg::reg_ix_w-1:0] rf_rd_addr,
  output logic [cpu_pkg::xlen-1:0]     rf_rd_data,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [wb_pkg::wb_addr_w-1:0] wb_adr,
  output logic [wb_pkg::wb_data_w-1:0] wb_dat_o,
  input  logic                         wb_ack
);
  import cpu_pkg::*;
  import wb_pkg::*;

  // architectural registers
  logic [xlen-1:0] rf [reg_count];

  wb_state_t wb_state;

  // async read for inspection
  assign rf_rd_data = rf[rf_rd_addr];

  // only writes go out on this port
  assign wb_we = 1'b1;

  // ack ends the store and frees the rob head
  assign store_done = (wb_state == wb_busy) && wb_ack;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < reg_count; i++) begin
        rf[i] <= '0;
      end
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= commit_valid;
      if (commit_valid) begin
        rf[head_rd] <= head_value;
      end
    end
  end

  // retire report for the cycle after the write
  always_ff @(posedge clk_in) begin
    if (commit_valid) begin
      retire_rd <= head_rd;
      retire_value <= head_value;
    end
  end

  // classic single write per store
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wb_state <= wb_idle;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else begin
      case (wb_state)
        wb_idle: begin
          if (store_valid) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_state <= wb_busy;
          end
        end
        wb_busy: begin
          // hold cyc and stb until the slave acks
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_state <= wb_idle;
          end
        end
        default: begin
          wb_cyc <= 1'b0;
          wb_stb <= 1'b0;
          wb_state <= wb_idle;
        end
      endcase
    end
  end

  // address and data frozen for the whole cycle
  always_ff @(posedge clk_in) begin
    if ((wb_state == wb_idle) && store_valid) begin
      wb_adr <= head_addr;
      wb_dat_o <= head_value;
    end
  end

endmodule

/* verilog/rob.sv */
`timescale 1ns/100ps

module rob #(
  parameter int rob_depth = 8
) (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         alloc_valid,
  input  cpu_pkg::op_t                 alloc_op,
  input  logic [cpu_pkg::reg_ix_w-1:0] alloc_rd,
  input  logic [cpu_pkg::imm_w-1:0]    alloc_imm,
  output logic                         alloc_ready,
  output logic [$clog2(rob_depth)-1:0] alloc_tag,
  input  logic                         cdb_valid,
  input  logic [$clog2(rob_depth)-1:0] cdb_tag,
  input  logic [cpu_pkg::xlen-1:0]     cdb_value,
  input  logic [cpu_pkg::xlen-1:0]     cdb_addr_base,
  output cpu_pkg::op_t                 head_op,
  output logic [cpu_pkg::reg_ix_w-1:0] head_rd,
  output logic [cpu_pkg::xlen-1:0]     head_value,
  output logic [cpu_pkg::xlen-1:0]     head_addr,
  output logic                         commit_valid,
  output logic                         store_valid,
  input  logic                         store_done
);
  import cpu_pkg::*;

  localparam int tag_w = $clog2(rob_depth);

  // entry storage
  op_t                 ent_op    [rob_depth];
  logic [reg_ix_w-1:0] ent_rd    [rob_depth];
  logic [xlen-1:0]     ent_value [rob_depth];
  logic [xlen-1:0]     ent_addr  [rob_depth];
  logic [rob_depth-1:0] ent_done;

  // extra msb tells full from empty
  logic [tag_w:0]   head;
  logic [tag_w:0]   tail;
  logic [tag_w-1:0] head_ix;
  logic [tag_w-1:0] tail_ix;

  logic empty;
  logic full;
  logic head_ready;
  logic head_is_store;
  logic retire;
  logic alloc_go;

  assign head_ix = head[tag_w-1:0];
  assign tail_ix = tail[tag_w-1:0];

  assign empty = (head == tail);
  assign full = (head[tag_w] != tail[tag_w]) && (head_ix == tail_ix);

  assign alloc_ready = !full;
  assign alloc_tag = tail_ix;
  assign alloc_go = alloc_valid && !full;

  // head entry seen by commit
  assign head_op = ent_op[head_ix];
  assign head_rd = ent_rd[head_ix];
  assign head_value = ent_value[head_ix];
  assign head_addr = ent_addr[head_ix];

  assign head_ready = !empty && ent_done[head_ix];
  assign head_is_store = (ent_op[head_ix] == op_store);
  assign commit_valid = head_ready && !head_is_store;
  assign store_valid = head_ready && head_is_store;

  // stores leave only once the bus write is acked
  assign retire = commit_valid || (store_valid && store_done);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head <= '0;
      tail <= '0;
      ent_done <= '0;
    end else begin
      if (alloc_go) begin
        ent_done[tail_ix] <= 1'b0;
        tail <= tail + 1'b1;
      end
      // results come back in any order
      if (cdb_valid) begin
        ent_done[cdb_tag] <= 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc_go) begin
      ent_op[tail_ix] <= alloc_op;
      ent_rd[tail_ix] <= alloc_rd;
      // partial address is the sign-extended offset
      ent_addr[tail_ix] <= {{(xlen - imm_w){alloc_imm[imm_w-1]}}, alloc_imm};
    end
    if (cdb_valid) begin
      ent_value[cdb_tag] <= cdb_value;
      // store address completes with operand a
      if (ent_op[cdb_tag] == op_store) begin
        ent_addr[cdb_tag] <= ent_addr[cdb_tag] + cdb_addr_base;
      end
    end
  end

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit #(
  parameter int rob_depth = 8
) (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         disp_fire,
  input  cpu_pkg::op_t                 disp_op,
  input  logic [cpu_pkg::xlen-1:0]     disp_a,
  input  logic [cpu_pkg::xlen-1:0]     disp_b,
  input  logic [$clog2(rob_depth)-1:0] disp_tag,
  output logic                         exec_ready,
  output logic                         cdb_valid,
  output logic [$clog2(rob_depth)-1:0] cdb_tag,
  output logic [cpu_pkg::xlen-1:0]     cdb_value,
  output logic [cpu_pkg::xlen-1:0]     cdb_addr_base
);
  import cpu_pkg::*;

  localparam int tag_w = $clog2(rob_depth);

  logic             alu_fire;
  logic             mul_fire;
  logic [xlen-1:0]  alu_value;

  // multiply stage 1 holds operands
  logic             m1_valid;
  logic [tag_w-1:0] m1_tag;
  logic [xlen-1:0]  m1_a;
  logic [xlen-1:0]  m1_b;

  // multiply stage 2 holds the low half of the product
  logic             m2_valid;
  logic [tag_w-1:0] m2_tag;
  logic [xlen-1:0]  m2_prod;

  assign alu_fire = disp_fire && (disp_op != op_mul);
  assign mul_fire = disp_fire && (disp_op == op_mul);

  // a single-cycle op would meet the stage 2 product on the bus
  assign exec_ready = !(m2_valid && (disp_op != op_mul));

  // store passes b through as the data word
  always_comb begin
    case (disp_op)
      op_add:   alu_value = disp_a + disp_b;
      op_sub:   alu_value = disp_a - disp_b;
      op_store: alu_value = disp_b;
      default:  alu_value = disp_a + disp_b;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      m1_valid <= 1'b0;
      m2_valid <= 1'b0;
      cdb_valid <= 1'b0;
    end else begin
      m1_valid <= mul_fire;
      m2_valid <= m1_valid;
      cdb_valid <= alu_fire || m2_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (mul_fire) begin
      m1_tag <= disp_tag;
      m1_a <= disp_a;
      m1_b <= disp_b;
    end
    if (m1_valid) begin
      m2_tag <= m1_tag;
      m2_prod <= m1_a * m1_b;
    end
    // result bus mux, multiply lane wins when it arrives
    if (m2_valid) begin
      cdb_tag <= m2_tag;
      cdb_value <= m2_prod;
      cdb_addr_base <= '0;
    end else if (alu_fire) begin
      cdb_tag <= disp_tag;
      cdb_value <= alu_value;
      cdb_addr_base <= disp_a;
    end
  end

endmodule

/* verilog/issue_unit.sv */
`timescale 1ns/100ps

module issue_unit (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         instr_valid,
  input  cpu_pkg::op_t                 instr_op,
  input  logic [cpu_pkg::reg_ix_w-1:0] instr_rd,
  input  logic [cpu_pkg::xlen-1:0]     instr_a,
  input  logic [cpu_pkg::xlen-1:0]     instr_b,
  input  logic [cpu_pkg::imm_w-1:0]    instr_imm,
  output logic                         instr_ready,
  input  logic                         alloc_ready,
  input  logic                         exec_ready,
  output logic                         disp_valid,
  output cpu_pkg::op_t                 disp_op,
  output logic [cpu_pkg::reg_ix_w-1:0] disp_rd,
  output logic [cpu_pkg::xlen-1:0]     disp_a,
  output logic [cpu_pkg::xlen-1:0]     disp_b,
  output logic [cpu_pkg::imm_w-1:0]    disp_imm
);
  import cpu_pkg::*;

  // one-entry holding register
  logic                hold_valid;
  op_t                 hold_op;
  logic [reg_ix_w-1:0] hold_rd;
  logic [xlen-1:0]     hold_a;
  logic [xlen-1:0]     hold_b;
  logic [imm_w-1:0]    hold_imm;

  // goes high one cycle after reset is released
  logic                live;

  logic                disp_go;
  logic                accept;

  // dispatch needs a free rob slot and a free exec lane
  assign disp_go = hold_valid && alloc_ready && exec_ready;

  // refill allowed in the same cycle as a dispatch
  assign instr_ready = live && (!hold_valid || disp_go);
  assign accept = instr_valid && instr_ready;

  assign disp_valid = hold_valid;
  assign disp_op = hold_op;
  assign disp_rd = hold_rd;
  assign disp_a = hold_a;
  assign disp_b = hold_b;
  assign disp_imm = hold_imm;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      hold_valid <= 1'b0;
      live <= 1'b0;
    end else begin
      live <= 1'b1;
      if (accept) begin
        hold_valid <= 1'b1;
      end else if (disp_go) begin
        hold_valid <= 1'b0;
      end
    end
  end

  // payload capture
  always_ff @(posedge clk_in) begin
    if (accept) begin
      hold_op <= instr_op;
      hold_rd <= instr_rd;
      hold_a <= instr_a;
      hold_b <= instr_b;
      hold_imm <= instr_imm;
    end
  end

endmodule

/* verilog/wb_pkg.sv */
package wb_pkg;

  // store port widths
  localparam int wb_addr_w = 32;
  localparam int wb_data_w = 32;

  // store master bus state
  typedef enum logic [1:0] {
    wb_idle = 2'd0,
    wb_busy = 2'd1
  } wb_state_t;

endpackage

/* verilog/cpu_pkg.sv */
package cpu_pkg;

  // datapath width
  localparam int xlen = 32;

  // architectural register file
  localparam int reg_count = 8;
  localparam int reg_ix_w = 3;

  // store offset, sign-extended to xlen
  localparam int imm_w = 16;

  // instruction opcodes
  typedef enum logic [1:0] {
    op_add   = 2'd0,
    op_sub   = 2'd1,
    op_mul   = 2'd2,
    op_store = 2'd3
  } op_t;

endpackage
